/* hdl/axil_obi_pkg.sv */
// Shared widths and channel types for the AXI4-Lite to OBI bridge
// AXI4-Lite only: no bursts, IDs, user fields or atomics
// OBI_MAX_TRANS must stay a power of two (arbiter queue pointers wrap)
package axil_obi_pkg;

  localparam int unsigned ADDR_WIDTH    = 32;
  localparam int unsigned DATA_WIDTH    = 32;
  localparam int unsigned STRB_WIDTH    = DATA_WIDTH / 8;
  localparam int unsigned OBI_MAX_TRANS = 2;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axil_resp_e;

  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RSP,
    RESPOND
  } chan_state_e;

  // AXI4-Lite beats
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  valid;
  } axil_ax_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  valid;
  } axil_w_t;

  typedef struct packed {
    axil_ax_t aw;
    axil_w_t  w;
    axil_ax_t ar;
    logic     bready;
    logic     rready;
  } axil_req_t;

  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic                  arready;
    logic                  bvalid;
    axil_resp_e            bresp;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
    axil_resp_e            rresp;
  } axil_rsp_t;

  // OBI A and R phases
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic                  we;
    logic [STRB_WIDTH-1:0] be;
    logic [DATA_WIDTH-1:0] wdata;
  } obi_a_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] rdata;
    logic                  err;
  } obi_r_chan_t;

  typedef struct packed {
    logic        req;
    obi_a_chan_t a;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    obi_r_chan_t r;
  } obi_rsp_t;

endpackage

/* hdl/axil_read_channel.sv */
// AXI4-Lite read channel, one transfer outstanding
// Always reads the full word; OBI err becomes SLVERR
`timescale 1ns/100ps

module axil_read_channel
  import axil_obi_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  axil_ax_t              ar_i,
  output logic                  arready_o,
  input  logic                  rready_i,
  output logic                  rvalid_o,
  output logic [DATA_WIDTH-1:0] rdata_o,
  output axil_resp_e            rresp_o,
  output obi_req_t              obi_req_o,
  input  obi_rsp_t              obi_rsp_i
);

  chan_state_e           state_q;
  chan_state_e           state_d;
  logic [ADDR_WIDTH-1:0] addr_q;

  assign arready_o = (state_q == IDLE);
  assign rvalid_o  = (state_q == RESPOND);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (ar_i.valid) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        if (obi_rsp_i.gnt) begin
          state_d = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (obi_rsp_i.rvalid) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (rready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Address and response payload
  always_ff @(posedge clk_i) begin
    if (arready_o && ar_i.valid) begin
      addr_q <= ar_i.addr;
    end
    if (state_q == WAIT_RSP && obi_rsp_i.rvalid) begin
      rdata_o <= obi_rsp_i.r.rdata;
      rresp_o <= obi_rsp_i.r.err ? SLVERR : OKAY;
    end
  end

  assign obi_req_o.req     = (state_q == ISSUE);
  assign obi_req_o.a.addr  = addr_q;
  assign obi_req_o.a.we    = 1'b0;
  assign obi_req_o.a.be    = '1;
  assign obi_req_o.a.wdata = '0;

endmodule

/* hdl/axil_write_channel.sv */
// AXI4-Lite write channel, one transfer outstanding
// AW and W are accepted in any order; strobe goes out as OBI byte enables
`timescale 1ns/100ps

module axil_write_channel
  import axil_obi_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_i,
  input  axil_ax_t   aw_i,
  output logic       awready_o,
  input  axil_w_t    w_i,
  output logic       wready_o,
  input  logic       bready_i,
  output logic       bvalid_o,
  output axil_resp_e bresp_o,
  output obi_req_t   obi_req_o,
  input  obi_rsp_t   obi_rsp_i
);

  chan_state_e           state_q;
  chan_state_e           state_d;
  logic                  aw_done_q;
  logic                  w_done_q;
  logic                  aw_hs;
  logic                  w_hs;
  logic                  both_have;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [DATA_WIDTH-1:0] data_q;
  logic [STRB_WIDTH-1:0] strb_q;

  // Each beat is taken once per transfer
  assign awready_o = (state_q == IDLE) && !aw_done_q;
  assign wready_o  = (state_q == IDLE) && !w_done_q;
  assign bvalid_o  = (state_q == RESPOND);

  assign aw_hs     = aw_i.valid && awready_o;
  assign w_hs      = w_i.valid && wready_o;
  assign both_have = (aw_done_q || aw_hs) && (w_done_q || w_hs);

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (both_have) begin
          state_d = ISSUE;
        end
      end
      ISSUE: begin
        if (obi_rsp_i.gnt) begin
          state_d = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if (obi_rsp_i.rvalid) begin
          state_d = RESPOND;
        end
      end
      RESPOND: begin
        if (bready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && both_have) begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end else begin
        aw_done_q <= aw_done_q || aw_hs;
        w_done_q  <= w_done_q || w_hs;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      addr_q <= aw_i.addr;
    end
    if (w_hs) begin
      data_q <= w_i.data;
      strb_q <= w_i.strb;
    end
    if (state_q == WAIT_RSP && obi_rsp_i.rvalid) begin
      bresp_o <= obi_rsp_i.r.err ? SLVERR : OKAY;
    end
  end

  assign obi_req_o.req     = (state_q == ISSUE);
  assign obi_req_o.a.addr  = addr_q;
  assign obi_req_o.a.we    = 1'b1;
  assign obi_req_o.a.be    = strb_q;
  assign obi_req_o.a.wdata = data_q;

endmodule

/* hdl/obi_arbiter_mux.sv */
// Two OBI managers onto one OBI subordinate port
// Round-robin on contention; responses return in grant order
`timescale 1ns/100ps

module obi_arbiter_mux
  import axil_obi_pkg::*;
(
  input  logic           clk_i,
  input  logic           rst_i,
  input  obi_req_t [1:0] mgr_req_i,
  output obi_rsp_t [1:0] mgr_rsp_o,
  output obi_req_t       sbr_req_o,
  input  obi_rsp_t       sbr_rsp_i
);

  // Owner of each transaction in flight, one bit per slot
  logic [OBI_MAX_TRANS-1:0]           owner_q;
  logic [$clog2(OBI_MAX_TRANS)-1:0]   wr_ptr_q;
  logic [$clog2(OBI_MAX_TRANS)-1:0]   rd_ptr_q;
  logic [$clog2(OBI_MAX_TRANS+1)-1:0] count_q;

  logic last_q;
  logic lock_q;
  logic lock_sel_q;
  logic sel;
  logic full;
  logic grant;
  logic owner;

  assign full  = (count_q == OBI_MAX_TRANS);
  assign owner = owner_q[rd_ptr_q];

  // Keep the choice while a request waits for gnt, so A stays stable
  always_comb begin
    if (lock_q) begin
      sel = lock_sel_q;
    end else if (mgr_req_i[0].req && mgr_req_i[1].req) begin
      sel = ~last_q;
    end else begin
      sel = mgr_req_i[1].req;
    end
  end

  assign sbr_req_o.req = mgr_req_i[sel].req && !full;
  assign sbr_req_o.a   = mgr_req_i[sel].a;
  assign grant         = sbr_req_o.req && sbr_rsp_i.gnt;

  for (genvar g = 0; g < 2; g++) begin : gen_rsp
    assign mgr_rsp_o[g].gnt    = grant && (sel == g);
    assign mgr_rsp_o[g].rvalid = sbr_rsp_i.rvalid && (owner == g);
    assign mgr_rsp_o[g].r      = sbr_rsp_i.r;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_q     <= 1'b1;
      lock_q     <= 1'b0;
      lock_sel_q <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
    end else begin
      lock_q     <= sbr_req_o.req && !sbr_rsp_i.gnt;
      lock_sel_q <= sel;
      if (grant) begin
        last_q   <= sel;
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (sbr_rsp_i.rvalid) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({grant, sbr_rsp_i.rvalid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      owner_q[wr_ptr_q] <= sel;
    end
  end

endmodule

/* hdl/axil_to_obi.sv */
// AXI4-Lite subordinate to OBI manager bridge
// Read and write channels run independently and share the OBI port
// Port 0 of the arbiter is the read side, port 1 the write side
`timescale 1ns/100ps

module axil_to_obi
  import axil_obi_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  axil_req_t axil_req_i,
  output axil_rsp_t axil_rsp_o,
  output obi_req_t  obi_req_o,
  input  obi_rsp_t  obi_rsp_i
);

  obi_req_t [1:0] chan_req;
  obi_rsp_t [1:0] chan_rsp;

  axil_read_channel u_read (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .ar_i      (axil_req_i.ar),
    .arready_o (axil_rsp_o.arready),
    .rready_i  (axil_req_i.rready),
    .rvalid_o  (axil_rsp_o.rvalid),
    .rdata_o   (axil_rsp_o.rdata),
    .rresp_o   (axil_rsp_o.rresp),
    .obi_req_o (chan_req[0]),
    .obi_rsp_i (chan_rsp[0])
  );

  axil_write_channel u_write (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .aw_i      (axil_req_i.aw),
    .awready_o (axil_rsp_o.awready),
    .w_i       (axil_req_i.w),
    .wready_o  (axil_rsp_o.wready),
    .bready_i  (axil_req_i.bready),
    .bvalid_o  (axil_rsp_o.bvalid),
    .bresp_o   (axil_rsp_o.bresp),
    .obi_req_o (chan_req[1]),
    .obi_rsp_i (chan_rsp[1])
  );

  obi_arbiter_mux u_arb (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .mgr_req_i (chan_req),
    .mgr_rsp_o (chan_rsp),
    .sbr_req_o (obi_req_o),
    .sbr_rsp_i (obi_rsp_i)
  );

endmodule

/* testbench/axil_obi_checker.sv */
// Watches the bridge ports and compares each B and R against a byte model
// Read data is compared only inside the window, above it only the response
// The model is defined once the first test has written every word in full
`timescale 1ns/100ps

module axil_obi_checker
  import axil_obi_pkg::*;
#(
  parameter int unsigned WIN_BYTES = 48
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  axil_req_t   axil_req_i,
  input  axil_rsp_t   axil_rsp_i,
  input  obi_req_t    obi_req_i,
  input  obi_rsp_t    obi_rsp_i,
  output int unsigned checks_o,
  output int unsigned errors_o
);

  string                 test_name = "none";
  logic [7:0]            model [WIN_BYTES];
  logic                  in_reset = 1'b1;
  logic [ADDR_WIDTH-1:0] aw_addr;
  logic [ADDR_WIDTH-1:0] ar_addr;
  logic [DATA_WIDTH-1:0] w_data;
  logic [STRB_WIDTH-1:0] w_strb;
  int unsigned           obi_writes = 0;
  int unsigned           checks = 0;
  int unsigned           errors = 0;

  assign checks_o = checks;
  assign errors_o = errors;

  function automatic axil_resp_e resp_for(input logic [ADDR_WIDTH-1:0] addr);
    return (addr < WIN_BYTES) ? OKAY : SLVERR;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] model_word(input logic [ADDR_WIDTH-1:0] addr);
    logic [DATA_WIDTH-1:0] word;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      word[8*b +: 8] = model[addr + b];
    end
    return word;
  endfunction

  task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] expected,
                             input logic [DATA_WIDTH-1:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  // Mid-cycle sampling; each handshake seen here completes at the next rising edge
  always @(negedge clk_i) begin
    if (rst_i) begin
      in_reset   = 1'b1;
      obi_writes = 0;
    end else begin
      if (in_reset) begin
        // arready, awready, wready, rvalid, bvalid, OBI req
        check_value("reset outputs", 32'h38,
                    DATA_WIDTH'({axil_rsp_i.arready, axil_rsp_i.awready, axil_rsp_i.wready,
                                 axil_rsp_i.rvalid, axil_rsp_i.bvalid, obi_req_i.req}));
        in_reset = 1'b0;
      end
      if (axil_req_i.aw.valid && axil_rsp_i.awready) begin
        aw_addr = axil_req_i.aw.addr;
      end
      if (axil_req_i.w.valid && axil_rsp_i.wready) begin
        w_data = axil_req_i.w.data;
        w_strb = axil_req_i.w.strb;
      end
      if (obi_req_i.req && obi_rsp_i.gnt && obi_req_i.a.we) begin
        obi_writes++;
      end
      // Reads always fetch the whole word
      if (obi_req_i.req && obi_rsp_i.gnt && !obi_req_i.a.we) begin
        check_value("OBI read be", DATA_WIDTH'({STRB_WIDTH{1'b1}}),
                    DATA_WIDTH'(obi_req_i.a.be));
      end
      if (axil_rsp_i.bvalid && axil_req_i.bready) begin
        check_value("OBI writes per B", 32'd1, DATA_WIDTH'(obi_writes));
        obi_writes = 0;
        check_value("bresp", DATA_WIDTH'(resp_for(aw_addr)), DATA_WIDTH'(axil_rsp_i.bresp));
        if (aw_addr < WIN_BYTES) begin
          for (int b = 0; b < STRB_WIDTH; b++) begin
            if (w_strb[b]) begin
              model[aw_addr + b] = w_data[8*b +: 8];
            end
          end
        end
      end
      if (axil_req_i.ar.valid && axil_rsp_i.arready) begin
        ar_addr = axil_req_i.ar.addr;
      end
      if (axil_rsp_i.rvalid && axil_req_i.rready) begin
        check_value("rresp", DATA_WIDTH'(resp_for(ar_addr)), DATA_WIDTH'(axil_rsp_i.rresp));
        if (ar_addr < WIN_BYTES) begin
          check_value("rdata", model_word(ar_addr), axil_rsp_i.rdata);
        end
      end
    end
  end

endmodule

/* testbench/tb_axil_to_obi.sv */
// Testbench for the AXI4-Lite to OBI bridge, with an OBI memory of 16 words
// Words at WIN_BYTES and above answer with err; the checker module compares
`timescale 1ns/100ps

module tb_axil_to_obi
  import axil_obi_pkg::*;
();

  localparam int unsigned MEM_WORDS  = 16;
  localparam int unsigned WIN_BYTES  = 48;
  localparam int unsigned WAIT_LIMIT = 400;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  axil_ax_t    aw = '0;
  axil_w_t     w = '0;
  axil_ax_t    ar = '0;
  logic        bready = 1'b0;
  logic        rready = 1'b0;
  logic        gnt = 1'b0;
  logic        rvalid = 1'b0;
  obi_r_chan_t r_beat = '0;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  obi_req_t    obi_req;
  obi_rsp_t    obi_rsp;
  int unsigned checks;
  int unsigned errors;

  // OBI responder state
  logic [DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic                  a_seen = 1'b0;
  obi_a_chan_t           a_held;
  obi_r_chan_t           rsp_q [$];
  int unsigned           due_q [$];
  int unsigned           cycle = 0;
  int unsigned           last_due = 0;

  // Address claims keep the two channels off the same word
  logic                  rd_busy = 1'b0;
  logic                  wr_busy = 1'b0;
  logic [ADDR_WIDTH-1:0] rd_addr = '0;
  logic [ADDR_WIDTH-1:0] wr_addr = '0;
  int unsigned           tests_run = 0;
  int unsigned           checks_mark = 0;
  int unsigned           errors_mark = 0;
  bit                    timed_out = 1'b0;

  assign axil_req = {aw, w, ar, bready, rready};
  assign obi_rsp  = {gnt, rvalid, r_beat};

  axil_to_obi dut0 (
    .clk_i      (clk),
    .rst_i      (rst),
    .axil_req_i (axil_req),
    .axil_rsp_o (axil_rsp),
    .obi_req_o  (obi_req),
    .obi_rsp_i  (obi_rsp)
  );

  axil_obi_checker #(.WIN_BYTES(WIN_BYTES)) chk0 (
    .clk_i      (clk),
    .rst_i      (rst),
    .axil_req_i (axil_req),
    .axil_rsp_i (axil_rsp),
    .obi_req_i  (obi_req),
    .obi_rsp_i  (obi_rsp),
    .checks_o   (checks),
    .errors_o   (errors)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    rready <= ($urandom_range(0, 3) != 0);
    bready <= ($urandom_range(0, 3) != 0);
  end

  // A phase sampled mid-cycle, the transfer happens at the next rising edge
  always @(negedge clk) begin
    a_seen = obi_req.req && gnt;
    a_held = obi_req.a;
  end

  always @(posedge clk) begin
    obi_r_chan_t rsp;
    int unsigned due;
    gnt    <= ($urandom_range(0, 2) != 0);
    rvalid <= 1'b0;
    if (rst) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] = 32'h9e37_79b9 * (i + 1);
      end
    end else if (a_seen) begin
      rsp.err   = (a_held.addr >= WIN_BYTES);
      rsp.rdata = rsp.err ? '0 : mem[a_held.addr[5:2]];
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (!rsp.err && a_held.we && a_held.be[b]) begin
          mem[a_held.addr[5:2]][8*b +: 8] = a_held.wdata[8*b +: 8];
        end
      end
      // 1 to 3 cycles after the grant, never overtaking an older response
      due      = cycle + $urandom_range(1, 3);
      last_due = (due > last_due) ? due : last_due + 1;
      rsp_q.push_back(rsp);
      due_q.push_back(last_due);
    end
    if (due_q.size() != 0 && due_q[0] == cycle) begin
      rvalid <= 1'b1;
      r_beat <= rsp_q.pop_front();
      void'(due_q.pop_front());
    end
    cycle = cycle + 1;
  end

  function automatic logic [ADDR_WIDTH-1:0] pick_addr();
    return ADDR_WIDTH'($urandom_range(0, MEM_WORDS - 1) * 4);
  endfunction

  task automatic finish_run();
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (timed_out || errors != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  endtask

  // After the first timeout every later transfer is skipped
  task automatic report_timeout(input string what);
    if (!timed_out) begin
      $display("ERROR: timeout while waiting for the %s", what);
    end
    timed_out = 1'b1;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s: %0d checks, %0d errors", chk0.test_name,
             checks - checks_mark, errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  // Order 0 drives AW and W together, 1 drives AW first, 2 drives W first
  task automatic do_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                          input logic [STRB_WIDTH-1:0] strb, input int order);
    bit aw_done = 1'b0;
    bit w_done = 1'b0;
    bit b_done = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !b_done && !timed_out; n++) begin
      @(posedge clk);
      aw.valid <= !aw_done && (order != 2 || n >= 2);
      aw.addr  <= addr;
      w.valid  <= !w_done && (order != 1 || n >= 2);
      w.data   <= data;
      w.strb   <= strb;
      @(negedge clk);
      aw_done = aw_done || (aw.valid && axil_rsp.awready);
      w_done  = w_done || (w.valid && axil_rsp.wready);
      b_done  = axil_rsp.bvalid && bready;
    end
    if (!b_done) begin
      report_timeout("write response on B");
    end
  endtask

  task automatic do_read(input logic [ADDR_WIDTH-1:0] addr);
    bit ar_done = 1'b0;
    bit r_done = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !r_done && !timed_out; n++) begin
      @(posedge clk);
      ar.valid <= !ar_done;
      ar.addr  <= addr;
      @(negedge clk);
      ar_done = ar_done || (ar.valid && axil_rsp.arready);
      r_done  = axil_rsp.rvalid && rready;
    end
    if (!r_done) begin
      report_timeout("read response on R");
    end
  endtask

  task automatic random_writes(input int count);
    logic [ADDR_WIDTH-1:0] addr;
    repeat (count) begin
      addr = pick_addr();
      if (rd_busy && addr == rd_addr) begin
        addr = addr ^ 32'h4;
      end
      wr_addr = addr;
      wr_busy = 1'b1;
      do_write(addr, $urandom(), STRB_WIDTH'($urandom_range(1, 15)), $urandom_range(0, 2));
      wr_busy = 1'b0;
      repeat ($urandom_range(0, 3)) @(posedge clk);
    end
  endtask

  task automatic random_reads(input int count);
    logic [ADDR_WIDTH-1:0] addr;
    repeat (count) begin
      addr = pick_addr();
      if (wr_busy && addr == wr_addr) begin
        addr = addr ^ 32'h4;
      end
      rd_addr = addr;
      rd_busy = 1'b1;
      do_read(addr);
      rd_busy = 1'b0;
      repeat ($urandom_range(0, 3)) @(posedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'hc9c8));
    chk0.test_name = "reset_values";
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    end_test();

    // Full-word writes to every word, cycling through the AW/W orders
    chk0.test_name = "write_order";
    for (int i = 0; i < MEM_WORDS; i++) begin
      do_write(ADDR_WIDTH'(i * 4), $urandom(), '1, i % 3);
    end
    end_test();

    chk0.test_name = "read_back";
    for (int i = 0; i < 24; i++) begin
      do_write(pick_addr(), $urandom(), STRB_WIDTH'($urandom_range(1, 15)), i % 3);
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      do_read(ADDR_WIDTH'(i * 4));
    end
    end_test();

    chk0.test_name = "concurrent_random";
    fork
      random_writes(40);
      random_reads(40);
    join
    end_test();
    finish_run();
  end

endmodule

/* verilog.f */
hdl/axil_obi_pkg.sv
hdl/axil_read_channel.sv
hdl/axil_write_channel.sv
hdl/obi_arbiter_mux.sv
hdl/axil_to_obi.sv
testbench/axil_obi_checker.sv
testbench/tb_axil_to_obi.sv

/* run_sim.sh */
#!/bin/sh
# Builds the bridge testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_axil_to_obi -f verilog.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_axil_to_obi)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
  exit 0
fi
exit 1
